/* files.f */
fifo_pkg.sv
sp_sram.sv
single_fifo_control.sv
queue_cmd_demux.sv
queue_rsp_merge.sv
multi_fifo_top.sv
tb_multi_fifo.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it, a failing run gives a nonzero status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tb_multi_fifo &&
./obj_dir/Vtb_multi_fifo || exit 1

/* tb_multi_fifo.sv */
// testbench for the multi-queue FIFO
// drives random commands from a fixed seed and checks them against a per-queue model
`default_nettype none

module tb_multi_fifo
  import fifo_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_QUEUES = 4;
  localparam int DEPTH = 16;
  localparam int DATA_WIDTH = 32;
  // ids up to twice the queue count, so out-of-range ids can be sent
  localparam int QID_WIDTH = 3;
  localparam int NUM_CMDS = 2000;
  localparam int PHASE_LEN = 160;
  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_CYCLES = 8;
  // response shows up four falling edges after the command was driven
  localparam int LATENCY = 4;
  localparam int WATCHDOG_CYCLES = NUM_CMDS + 50;

  // one expected response per driven cycle, valid low for idle cycles
  typedef struct packed {
    logic                  valid;
    logic [QID_WIDTH-1:0]  qid;
    logic [1:0]            cmd;
    logic                  err_uf;
    logic                  err_of;
    logic                  err_qid;
    logic                  check_data;
    logic [DATA_WIDTH-1:0] data;
  } rsp_t;

  typedef struct packed {
    logic [NUM_QUEUES-1:0] full;
    logic [NUM_QUEUES-1:0] empty;
  } status_t;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  cmd_v;
  fifo_cmd_t             cmd;
  logic [QID_WIDTH-1:0]  cmd_qid;
  logic [DATA_WIDTH-1:0] push_data;
  logic                  rsp_v;
  logic [QID_WIDTH-1:0]  rsp_qid;
  fifo_cmd_t             rsp_cmd;
  logic [DATA_WIDTH-1:0] pop_data;
  logic                  err_uf;
  logic                  err_of;
  logic                  err_qid;
  logic [NUM_QUEUES-1:0] full_vec;
  logic [NUM_QUEUES-1:0] empty_vec;

  // the model keeps each queue as a ring with a head index and a count
  logic [DATA_WIDTH-1:0] model_data [NUM_QUEUES][DEPTH];
  int                    model_head [NUM_QUEUES];
  int                    model_cnt  [NUM_QUEUES];
  rsp_t                  exp_rsp_q [$];
  status_t               exp_status_q [$];
  int                    seed;

  multi_fifo_top #(
    .NUM_QUEUES (NUM_QUEUES),
    .DEPTH      (DEPTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_multi_fifo_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_v     (cmd_v),
    .cmd       (cmd),
    .cmd_qid   (cmd_qid),
    .push_data (push_data),
    .rsp_v     (rsp_v),
    .rsp_qid   (rsp_qid),
    .rsp_cmd   (rsp_cmd),
    .pop_data  (pop_data),
    .err_uf    (err_uf),
    .err_of    (err_of),
    .err_qid   (err_qid),
    .full_vec  (full_vec),
    .empty_vec (empty_vec)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      stop_with_failure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // uniform draw below n from the seeded generator
  function automatic int unsigned draw_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // after reset nothing may answer and every queue reads as empty
  task automatic check_idle();
    check_value("rsp_v", 64'(rsp_v), 64'd0);
    check_value("err_uf", 64'(err_uf), 64'd0);
    check_value("err_of", 64'(err_of), 64'd0);
    check_value("err_qid", 64'(err_qid), 64'd0);
    check_value("full_vec", 64'(full_vec), 64'd0);
    check_value("empty_vec", 64'(empty_vec), 64'((1 << NUM_QUEUES) - 1));
  endtask

  // compares the response owed by the command driven LATENCY cycles ago
  task automatic check_response_due();
    rsp_t e;
    if (exp_rsp_q.size() >= LATENCY) begin
      e = exp_rsp_q.pop_front();
      check_value("rsp_v", 64'(rsp_v), 64'(e.valid));
      check_value("err_uf", 64'(err_uf), 64'(e.err_uf));
      check_value("err_of", 64'(err_of), 64'(e.err_of));
      check_value("err_qid", 64'(err_qid), 64'(e.err_qid));
      if (e.valid) begin
        check_value("rsp_qid", 64'(rsp_qid), 64'(e.qid));
        check_value("rsp_cmd", 64'(rsp_cmd), 64'(e.cmd));
        // data is only defined for a pop that found an entry
        if (e.check_data) begin
          check_value("pop_data", 64'(pop_data), 64'(e.data));
        end
      end
    end
  endtask

  // status vectors trail the command by two falling edges
  task automatic check_status_due();
    status_t s;
    if (exp_status_q.size() >= 2) begin
      s = exp_status_q.pop_front();
      check_value("full_vec", 64'(full_vec), 64'(s.full));
      check_value("empty_vec", 64'(empty_vec), 64'(s.empty));
    end
  endtask

  // --------------------------------------------------
  // stimulus and model update
  // --------------------------------------------------
  task automatic drive_command(input bit active, input int index);
    int unsigned           pick;
    int                    q;
    logic                  go;
    fifo_cmd_t             c;
    logic [QID_WIDTH-1:0]  qid;
    logic [DATA_WIDTH-1:0] data;
    rsp_t                  e;
    status_t               s;
    go = active && (draw_below(16) != 0);
    pick = draw_below(10);
    // even phases lean toward pushes, odd phases toward pops
    if (pick == 0) begin
      c = fifo_nop;
    end else if ((index / PHASE_LEN) % 2 == 0) begin
      c = (pick <= 7) ? fifo_push : fifo_pop;
    end else begin
      c = (pick <= 2) ? fifo_push : fifo_pop;
    end
    // about one id in eight lands outside the queue range
    if (draw_below(8) == 0) begin
      qid = QID_WIDTH'(NUM_QUEUES + draw_below(NUM_QUEUES));
    end else begin
      qid = QID_WIDTH'(draw_below(NUM_QUEUES));
    end
    data = DATA_WIDTH'($random(seed));
    e = '0;
    e.valid = go;
    if (go) begin
      e.cmd = c;
      if (qid >= QID_WIDTH'(NUM_QUEUES)) begin
        e.qid = '1;
        e.err_qid = 1'b1;
      end else begin
        q = int'(qid);
        e.qid = qid;
        if (c == fifo_push) begin
          if (model_cnt[q] == DEPTH) begin
            e.err_of = 1'b1;
          end else begin
            model_data[q][(model_head[q] + model_cnt[q]) % DEPTH] = data;
            model_cnt[q]++;
          end
        end else if (c == fifo_pop) begin
          if (model_cnt[q] == 0) begin
            e.err_uf = 1'b1;
          end else begin
            e.check_data = 1'b1;
            e.data = model_data[q][model_head[q]];
            model_head[q] = (model_head[q] + 1) % DEPTH;
            model_cnt[q]--;
          end
        end
      end
    end
    for (int i = 0; i < NUM_QUEUES; i++) begin
      s.full[i] = (model_cnt[i] == DEPTH);
      s.empty[i] = (model_cnt[i] == 0);
    end
    exp_rsp_q.push_back(e);
    exp_status_q.push_back(s);
    cmd_v = go;
    cmd = c;
    cmd_qid = qid;
    push_data = data;
  endtask

  initial begin : stimulus
    seed = 32'h6794;
    rst_n = 1'b0;
    cmd_v = 1'b0;
    cmd = fifo_nop;
    cmd_qid = '0;
    push_data = '0;
    for (int i = 0; i < NUM_QUEUES; i++) begin
      model_head[i] = 0;
      model_cnt[i] = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      check_idle();
    end
    // the last LATENCY cycles stay idle so every response gets checked
    for (int i = 0; i < NUM_CMDS + LATENCY; i++) begin
      @(negedge clk);
      check_response_due();
      check_status_due();
      drive_command(i < NUM_CMDS, i);
    end
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_with_failure("timeout, the test did not finish within the expected time");
  end

endmodule

`default_nettype wire

/* multi_fifo_top.sv */
// top of the multi-queue FIFO
// a demux, one controller and SRAM per queue, and a response merge
`default_nettype none

module multi_fifo_top
  import fifo_pkg::*;
#(
  parameter int NUM_QUEUES = NUM_QUEUES_DEF,
  parameter int DEPTH      = DEPTH_DEF,
  parameter int DATA_WIDTH = $bits(fifo_data_t),
  // the id field holds twice the queue count so that bad ids can be sent
  localparam int QID_WIDTH  = fifo_clog2(2 * NUM_QUEUES),
  localparam int ADDR_WIDTH = fifo_clog2(DEPTH)
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  cmd_v,
  input  wire fifo_cmd_t             cmd,
  input  wire logic [QID_WIDTH-1:0]  cmd_qid,
  input  wire logic [DATA_WIDTH-1:0] push_data,
  output logic                       rsp_v,
  output logic      [QID_WIDTH-1:0]  rsp_qid,
  output fifo_cmd_t                  rsp_cmd,
  output logic      [DATA_WIDTH-1:0] pop_data,
  output logic                       err_uf,
  output logic                       err_of,
  output logic                       err_qid,
  output logic      [NUM_QUEUES-1:0] full_vec,
  output logic      [NUM_QUEUES-1:0] empty_vec
);

  // per-queue wires between the controllers and the merge
  logic      [NUM_QUEUES-1:0] ctl_cmd_v;
  logic      [NUM_QUEUES-1:0] ctl_rsp_v;
  logic      [NUM_QUEUES-1:0] ctl_err_uf;
  logic      [NUM_QUEUES-1:0] ctl_err_of;
  logic      [NUM_QUEUES-1:0] ctl_full;
  logic      [NUM_QUEUES-1:0] ctl_empty;
  fifo_cmd_t                  ctl_rsp_cmd [NUM_QUEUES];
  logic      [DATA_WIDTH-1:0] ctl_pop_data [NUM_QUEUES];
  logic                       qerr_v;
  fifo_cmd_t                  qerr_cmd;

  queue_cmd_demux #(
    .NUM_QUEUES (NUM_QUEUES),
    .QID_WIDTH  (QID_WIDTH)
  ) u_queue_cmd_demux (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_v     (cmd_v),
    .cmd       (cmd),
    .cmd_qid   (cmd_qid),
    .ctl_cmd_v (ctl_cmd_v),
    .qerr_v    (qerr_v),
    .qerr_cmd  (qerr_cmd)
  );

  // --------------------------------------------------
  // one controller and one SRAM per queue
  // --------------------------------------------------
  for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
    logic                  sram_re;
    logic                  sram_we;
    logic [ADDR_WIDTH-1:0] sram_addr;
    logic [DATA_WIDTH-1:0] sram_wdata;
    logic [DATA_WIDTH-1:0] sram_rdata;

    // cmd and push_data reach every controller, only the strobe is steered
    single_fifo_control #(
      .DEPTH      (DEPTH),
      .DATA_WIDTH (DATA_WIDTH)
    ) u_single_fifo_control (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_v      (ctl_cmd_v[q]),
      .cmd        (cmd),
      .push_data  (push_data),
      .rsp_v      (ctl_rsp_v[q]),
      .rsp_cmd    (ctl_rsp_cmd[q]),
      .err_uf     (ctl_err_uf[q]),
      .err_of     (ctl_err_of[q]),
      .pop_data   (ctl_pop_data[q]),
      .full       (ctl_full[q]),
      .empty      (ctl_empty[q]),
      .sram_re    (sram_re),
      .sram_we    (sram_we),
      .sram_addr  (sram_addr),
      .sram_wdata (sram_wdata),
      .sram_rdata (sram_rdata)
    );

    sp_sram #(
      .DEPTH      (DEPTH),
      .DATA_WIDTH (DATA_WIDTH)
    ) u_sp_sram (
      .clk   (clk),
      .re    (sram_re),
      .we    (sram_we),
      .addr  (sram_addr),
      .wdata (sram_wdata),
      .rdata (sram_rdata)
    );
  end

  queue_rsp_merge #(
    .NUM_QUEUES (NUM_QUEUES),
    .DATA_WIDTH (DATA_WIDTH),
    .QID_WIDTH  (QID_WIDTH)
  ) u_queue_rsp_merge (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctl_rsp_v    (ctl_rsp_v),
    .ctl_rsp_cmd  (ctl_rsp_cmd),
    .ctl_err_uf   (ctl_err_uf),
    .ctl_err_of   (ctl_err_of),
    .ctl_pop_data (ctl_pop_data),
    .ctl_full     (ctl_full),
    .ctl_empty    (ctl_empty),
    .qerr_v       (qerr_v),
    .qerr_cmd     (qerr_cmd),
    .rsp_v        (rsp_v),
    .rsp_qid      (rsp_qid),
    .rsp_cmd      (rsp_cmd),
    .pop_data     (pop_data),
    .err_uf       (err_uf),
    .err_of       (err_of),
    .err_qid      (err_qid),
    .full_vec     (full_vec),
    .empty_vec    (empty_vec)
  );

endmodule

`default_nettype wire

/* queue_rsp_merge.sv */
// response merge for the multi-queue FIFO
// folds the controller responses into one registered port plus status vectors
`default_nettype none

module queue_rsp_merge
  import fifo_pkg::*;
#(
  parameter int NUM_QUEUES = 4,
  parameter int DATA_WIDTH = 32,
  parameter int QID_WIDTH  = 3
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic [NUM_QUEUES-1:0] ctl_rsp_v,
  input  wire fifo_cmd_t             ctl_rsp_cmd [NUM_QUEUES],
  input  wire logic [NUM_QUEUES-1:0] ctl_err_uf,
  input  wire logic [NUM_QUEUES-1:0] ctl_err_of,
  input  wire logic [DATA_WIDTH-1:0] ctl_pop_data [NUM_QUEUES],
  input  wire logic [NUM_QUEUES-1:0] ctl_full,
  input  wire logic [NUM_QUEUES-1:0] ctl_empty,
  input  wire logic                  qerr_v,
  input  wire fifo_cmd_t             qerr_cmd,
  output logic                       rsp_v,
  output logic      [QID_WIDTH-1:0]  rsp_qid,
  output fifo_cmd_t                  rsp_cmd,
  output logic      [DATA_WIDTH-1:0] pop_data,
  output logic                       err_uf,
  output logic                       err_of,
  output logic                       err_qid,
  output logic      [NUM_QUEUES-1:0] full_vec,
  output logic      [NUM_QUEUES-1:0] empty_vec
);

  logic                  sel_v;
  logic [QID_WIDTH-1:0]  sel_qid;
  fifo_cmd_t             sel_cmd;
  logic [DATA_WIDTH-1:0] sel_data;
  logic                  sel_uf;
  logic                  sel_of;

  // only one source can be valid in a cycle since one command enters per cycle
  always_comb begin
    sel_v    = 1'b0;
    sel_qid  = '0;
    sel_cmd  = fifo_nop;
    sel_data = '0;
    sel_uf   = 1'b0;
    sel_of   = 1'b0;
    for (int i = 0; i < NUM_QUEUES; i++) begin
      if (ctl_rsp_v[i]) begin
        sel_v    = 1'b1;
        sel_qid  = QID_WIDTH'(i);
        sel_cmd  = ctl_rsp_cmd[i];
        sel_data = ctl_pop_data[i];
        sel_uf   = ctl_err_uf[i];
        sel_of   = ctl_err_of[i];
      end
    end
    // a bad id has no owner, so it reports the all-ones id
    if (qerr_v) begin
      sel_v   = 1'b1;
      sel_qid = '1;
      sel_cmd = qerr_cmd;
    end
  end

  // --------------------------------------------------
  // output registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_v     <= 1'b0;
      rsp_qid   <= '0;
      rsp_cmd   <= fifo_nop;
      err_uf    <= 1'b0;
      err_of    <= 1'b0;
      err_qid   <= 1'b0;
      full_vec  <= '0;
      empty_vec <= '1;
    end else begin
      rsp_v     <= sel_v;
      rsp_qid   <= sel_qid;
      rsp_cmd   <= sel_cmd;
      err_uf    <= sel_uf;
      err_of    <= sel_of;
      err_qid   <= qerr_v;
      full_vec  <= ctl_full;
      empty_vec <= ctl_empty;
    end
  end

  // pop data is only read for an error-free pop
  always_ff @(posedge clk) begin
    pop_data <= sel_data;
  end

endmodule

`default_nettype wire

/* queue_cmd_demux.sv */
// command demux for the multi-queue FIFO
// steers the command strobe to one controller and delays bad-id errors
`default_nettype none

module queue_cmd_demux
  import fifo_pkg::*;
#(
  parameter int NUM_QUEUES = 4,
  parameter int QID_WIDTH  = 3
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  cmd_v,
  input  wire fifo_cmd_t             cmd,
  input  wire logic [QID_WIDTH-1:0]  cmd_qid,
  output logic      [NUM_QUEUES-1:0] ctl_cmd_v,
  output logic                       qerr_v,
  output fifo_cmd_t                  qerr_cmd
);

  // an id is only legal below NUM_QUEUES, the id field can hold more
  logic      qid_bad;
  logic      [2:0] qerr_v_pipe;
  fifo_cmd_t qerr_cmd_pipe [3];

  assign qid_bad = (cmd_qid >= QID_WIDTH'(NUM_QUEUES));

  // one-hot strobe, an out-of-range id matches no controller at all
  always_comb begin
    for (int i = 0; i < NUM_QUEUES; i++) begin
      ctl_cmd_v[i] = cmd_v & (cmd_qid == QID_WIDTH'(i));
    end
  end

  // --------------------------------------------------
  // bad-id delay line
  // --------------------------------------------------
  // three stages match p0, p1 and p2 of a controller, so the error
  // shows up at the merge in the same cycle a controller would answer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      qerr_v_pipe <= '0;
    end else begin
      qerr_v_pipe <= {qerr_v_pipe[1:0], cmd_v & qid_bad};
    end
  end

  // the command only matters while the matching valid is set
  always_ff @(posedge clk) begin
    qerr_cmd_pipe[0] <= cmd;
    qerr_cmd_pipe[1] <= qerr_cmd_pipe[0];
    qerr_cmd_pipe[2] <= qerr_cmd_pipe[1];
  end

  assign qerr_v   = qerr_v_pipe[2];
  assign qerr_cmd = qerr_cmd_pipe[2];

endmodule

`default_nettype wire

/* single_fifo_control.sv */
// control for one queue of the multi-queue FIFO
// keeps pointers and occupancy and runs the three-stage SRAM pipeline
`default_nettype none

module single_fifo_control
  import fifo_pkg::*;
#(
  parameter int DEPTH      = 16,
  parameter int DATA_WIDTH = 32,
  localparam int PTR_WIDTH = fifo_clog2(DEPTH),
  localparam int CNT_WIDTH = fifo_clog2(DEPTH + 1)
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  cmd_v,
  input  wire fifo_cmd_t             cmd,
  input  wire logic [DATA_WIDTH-1:0] push_data,
  output logic                       rsp_v,
  output fifo_cmd_t                  rsp_cmd,
  output logic                       err_uf,
  output logic                       err_of,
  output logic      [DATA_WIDTH-1:0] pop_data,
  output logic                       full,
  output logic                       empty,
  output logic                       sram_re,
  output logic                       sram_we,
  output logic      [PTR_WIDTH-1:0]  sram_addr,
  output logic      [DATA_WIDTH-1:0] sram_wdata,
  input  wire logic [DATA_WIDTH-1:0] sram_rdata
);

  // --------------------------------------------------
  // queue state
  // --------------------------------------------------
  logic [PTR_WIDTH-1:0] wp_q;
  logic [PTR_WIDTH-1:0] wp_nxt;
  logic [PTR_WIDTH-1:0] rp_q;
  logic [PTR_WIDTH-1:0] rp_nxt;
  logic [CNT_WIDTH-1:0] cnt_q;
  logic [CNT_WIDTH-1:0] cnt_nxt;

  logic is_push;
  logic is_pop;
  logic acc_err_uf;
  logic acc_err_of;
  logic acc_ok;

  // pipeline stages, the valids are control and the rest is payload
  logic                  p0_v;
  fifo_cmd_t             p0_cmd;
  logic                  p0_err_uf;
  logic                  p0_err_of;
  logic [PTR_WIDTH-1:0]  p0_addr;
  logic [DATA_WIDTH-1:0] p0_data;
  logic                  p0_ok;

  logic                  p1_v;
  fifo_cmd_t             p1_cmd;
  logic                  p1_err_uf;
  logic                  p1_err_of;

  logic                  p2_v;
  fifo_cmd_t             p2_cmd;
  logic                  p2_err_uf;
  logic                  p2_err_of;
  logic [DATA_WIDTH-1:0] p2_data;

  // pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign is_push = (cmd == fifo_push);
  assign is_pop  = (cmd == fifo_pop);

  // errors are judged against the occupancy at the moment of acceptance
  assign acc_err_uf = is_pop & (cnt_q == '0);
  assign acc_err_of = is_push & (cnt_q == CNT_WIDTH'(DEPTH));
  assign acc_ok     = cmd_v & ~acc_err_uf & ~acc_err_of;

  // a failed command leaves the queue exactly as it was
  always_comb begin
    cnt_nxt = cnt_q;
    wp_nxt  = wp_q;
    rp_nxt  = rp_q;
    if (acc_ok && is_push) begin
      cnt_nxt = cnt_q + 1'b1;
      wp_nxt  = ptr_inc(wp_q);
    end
    if (acc_ok && is_pop) begin
      cnt_nxt = cnt_q - 1'b1;
      rp_nxt  = ptr_inc(rp_q);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wp_q  <= '0;
      rp_q  <= '0;
      cnt_q <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
      p0_v  <= 1'b0;
      p1_v  <= 1'b0;
      p2_v  <= 1'b0;
    end else begin
      wp_q  <= wp_nxt;
      rp_q  <= rp_nxt;
      cnt_q <= cnt_nxt;
      // status follows the occupancy after this cycle's command
      full  <= (cnt_nxt == CNT_WIDTH'(DEPTH));
      empty <= (cnt_nxt == '0);
      p0_v  <= cmd_v;
      p1_v  <= p0_v;
      p2_v  <= p1_v;
    end
  end

  // --------------------------------------------------
  // pipeline payload
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    // p0 takes the command along with its error bits and address
    if (cmd_v) begin
      p0_cmd    <= cmd;
      p0_err_uf <= acc_err_uf;
      p0_err_of <= acc_err_of;
      p0_addr   <= is_pop ? rp_q : wp_q;
      p0_data   <= push_data;
    end
    if (p0_v) begin
      p1_cmd    <= p0_cmd;
      p1_err_uf <= p0_err_uf;
      p1_err_of <= p0_err_of;
    end
    // read data from the SRAM is ready one cycle after the access
    if (p1_v) begin
      p2_cmd    <= p1_cmd;
      p2_err_uf <= p1_err_uf;
      p2_err_of <= p1_err_of;
      p2_data   <= sram_rdata;
    end
  end

  // p1 cycle, the SRAM is only touched by a command that passed its check
  assign p0_ok      = p0_v & ~p0_err_uf & ~p0_err_of;
  assign sram_re    = p0_ok & (p0_cmd == fifo_pop);
  assign sram_we    = p0_ok & (p0_cmd == fifo_push);
  assign sram_addr  = p0_addr;
  assign sram_wdata = p0_data;

  // p2 drives the response toward the merge
  assign rsp_v    = p2_v;
  assign rsp_cmd  = p2_cmd;
  assign err_uf   = p2_v & p2_err_uf;
  assign err_of   = p2_v & p2_err_of;
  assign pop_data = p2_data;

endmodule

`default_nettype wire

/* sp_sram.sv */
// behavioral single-port SRAM
// synchronous write and a registered read that holds without re
`default_nettype none

module sp_sram
  import fifo_pkg::*;
#(
  parameter int DEPTH      = 16,
  parameter int DATA_WIDTH = 32,
  localparam int ADDR_WIDTH = fifo_clog2(DEPTH)
) (
  input  wire logic                  clk,
  input  wire logic                  re,
  input  wire logic                  we,
  input  wire logic [ADDR_WIDTH-1:0] addr,
  input  wire logic [DATA_WIDTH-1:0] wdata,
  output logic      [DATA_WIDTH-1:0] rdata
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // the controller never asks for re and we in the same cycle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    if (re) begin
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

/* fifo_pkg.sv */
// shared definitions for the multi-queue FIFO
// holds the command encoding, the entry type and the width helper
`default_nettype none

package fifo_pkg;

  // defaults that the top level takes for its parameters
  parameter int DATA_WIDTH_DEF = 32;
  parameter int DEPTH_DEF = 16;
  parameter int NUM_QUEUES_DEF = 4;

  // one queue entry, as wide as the default data path
  typedef logic [DATA_WIDTH_DEF-1:0] fifo_data_t;

  // command encoding on the input port and through the pipelines
  // nop still travels the pipe and gets a response
  typedef enum logic [1:0] {
    fifo_nop  = 2'd0,
    fifo_push = 2'd1,
    fifo_pop  = 2'd2
  } fifo_cmd_t;

  // ceiling of log2, never below 1 so that a width of zero cannot appear
  // pointers, occupancy counters and queue ids are all sized with it
  function automatic int fifo_clog2(input int value);
    int result;
    result = 0;
    while ((1 << result) < value) begin
      result++;
    end
    if (result < 1) begin
      result = 1;
    end
    return result;
  endfunction

endpackage

`default_nettype wire
